//--- tb.f
+incdir+include
source/isa_pkg.sv
source/pipe_pkg.sv
source/pipe_reg.sv
source/reg_file.sv
source/alu.sv
source/decoder.sv
source/hazard_unit.sv
source/cpu.sv
tests/cpu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = cpu_tb
FILELIST = tb.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/test_programs.svh
`ifndef TEST_PROGRAMS_SVH
`define TEST_PROGRAMS_SVH

// opens a new table entry
task automatic start_test(input string name);
	test_name[num_tests] = name;
	prog_len[num_tests] = 0;
	store_count[num_tests] = 0;
	num_tests++;
endtask

task automatic add_instr(input logic [31:0] word);
	int cur;
	cur = num_tests - 1;
	prog[cur][prog_len[cur]] = word;
	prog_len[cur]++;
endtask

// src is the byte address of an initial data word added to data, or no_src
task automatic expect_store(input logic [31:0] addr, input logic [31:0] data, input int src);
	int cur;
	cur = num_tests - 1;
	exp_addr[cur][store_count[cur]] = addr;
	exp_data[cur][store_count[cur]] = data;
	exp_src[cur][store_count[cur]] = src;
	store_count[cur]++;
endtask

// every program ends with a store of x0 to the halt address
task automatic add_halt();
	add_instr(sw(5'd0, 5'd0, halt_addr));
	expect_store(halt_addr, 32'd0, no_src);
endtask

task automatic build_table();
	// each result feeds the next through the memory and writeback bypass
	start_test("forward_chain");
	add_instr(addi(5'd1, 5'd0, 32'd7));
	add_instr(addi(5'd2, 5'd1, 32'd5));
	add_instr(rtype(f7_base, isa_pkg::f3_add_sub, 5'd3, 5'd2, 5'd1));
	add_instr(rtype(isa_pkg::funct7_sub, isa_pkg::f3_add_sub, 5'd4, 5'd3, 5'd2));
	add_instr(rtype(f7_base, isa_pkg::f3_xor, 5'd5, 5'd4, 5'd3));
	add_instr(rtype(f7_base, isa_pkg::f3_or, 5'd6, 5'd5, 5'd4));
	add_instr(rtype(f7_base, isa_pkg::f3_and, 5'd7, 5'd6, 5'd3));
	add_instr(rtype(f7_base, isa_pkg::f3_slt, 5'd8, 5'd4, 5'd3));
	// x9 = -3
	add_instr(addi(5'd9, 5'd0, 32'hffff_fffd));
	add_instr(rtype(f7_base, isa_pkg::f3_slt, 5'd10, 5'd9, 5'd8));
	add_instr(sw(5'd10, 5'd0, 32'h18));
	add_instr(sw(5'd7, 5'd0, 32'h10));
	add_instr(sw(5'd5, 5'd0, 32'h14));
	add_instr(sw(5'd6, 5'd0, 32'h1c));
	// signed -3 < 1, then 23 & 19, 7 ^ 19, 20 | 7
	expect_store(32'h18, 32'd1, no_src);
	expect_store(32'h10, 32'd19, no_src);
	expect_store(32'h14, 32'd20, no_src);
	expect_store(32'h1c, 32'd23, no_src);
	add_halt();

	// dependent add and store right behind their loads
	start_test("load_use");
	add_instr(addi(5'd3, 5'd0, 32'd100));
	add_instr(lw(5'd1, 5'd0, 32'h40));
	add_instr(rtype(f7_base, isa_pkg::f3_add_sub, 5'd2, 5'd1, 5'd3));
	add_instr(sw(5'd2, 5'd0, 32'h20));
	add_instr(lw(5'd4, 5'd0, 32'h44));
	add_instr(sw(5'd4, 5'd0, 32'h24));
	expect_store(32'h20, 32'd100, 32'h40);
	expect_store(32'h24, 32'd0, 32'h44);
	add_halt();

	// taken beq over two stores, then a beq that falls through
	start_test("branch");
	add_instr(addi(5'd1, 5'd0, 32'd9));
	add_instr(addi(5'd2, 5'd0, 32'd9));
	add_instr(beq(5'd1, 5'd2, 32'd12));
	add_instr(sw(5'd1, 5'd0, 32'h30));
	add_instr(sw(5'd2, 5'd0, 32'h34));
	add_instr(addi(5'd3, 5'd0, 32'd4));
	add_instr(beq(5'd1, 5'd3, 32'd8));
	add_instr(sw(5'd3, 5'd0, 32'h38));
	add_instr(sw(5'd1, 5'd0, 32'h3c));
	expect_store(32'h38, 32'd4, no_src);
	expect_store(32'h3c, 32'd9, no_src);
	add_halt();

	// jal at address 4 links 8 and lands on the store of x1
	start_test("jal_link");
	add_instr(addi(5'd5, 5'd0, 32'd1));
	add_instr(jal(5'd1, 32'd12));
	add_instr(sw(5'd5, 5'd0, 32'h50));
	add_instr(sw(5'd5, 5'd0, 32'h54));
	add_instr(sw(5'd1, 5'd0, 32'h58));
	expect_store(32'h58, 32'd8, no_src);
	add_halt();

	// writes to x0 vanish even while still in the pipeline
	start_test("x0_discard");
	add_instr(addi(5'd0, 5'd0, 32'd55));
	add_instr(addi(5'd1, 5'd0, 32'd3));
	add_instr(rtype(f7_base, isa_pkg::f3_add_sub, 5'd0, 5'd1, 5'd1));
	add_instr(sw(5'd0, 5'd0, 32'h60));
	add_instr(addi(5'd2, 5'd0, 32'd11));
	add_instr(sw(5'd2, 5'd0, 32'h64));
	expect_store(32'h60, 32'd0, no_src);
	expect_store(32'h64, 32'd11, no_src);
	add_halt();
endtask

`endif

//--- tests/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

	localparam int max_tests = 8;
	localparam int max_instr = 16;
	localparam int max_stores = 8;
	localparam int imem_words = 64;
	localparam int dmem_words = 256;
	localparam int reset_cycles = 10;
	localparam int timeout_cycles = 200;
	localparam int no_src = -1;
	localparam logic [31:0] imem_bytes = 32'd256;
	localparam logic [31:0] halt_addr = 32'h0000_03fc;
	localparam logic [31:0] start_pc = 32'h0000_0000;
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [2:0] f3_word = 3'b010;
	localparam logic [2:0] f3_beq = 3'b000;

	logic clock = 1'b0;
	logic reset;
	logic [31:0] pc;
	logic [31:0] instr;
	logic [31:0] data_addr;
	logic data_read;
	logic data_write;
	logic [31:0] data_wdata;
	logic [31:0] data_rdata;

	logic [31:0] imem [imem_words];
	logic [31:0] dmem [dmem_words];
	logic [31:0] dmem_init [dmem_words];

	// test table filled by build_table
	int num_tests;
	string test_name [max_tests];
	logic [31:0] prog [max_tests][max_instr];
	int prog_len [max_tests];
	int store_count [max_tests];
	logic [31:0] exp_addr [max_tests][max_stores];
	logic [31:0] exp_data [max_tests][max_stores];
	int exp_src [max_tests][max_stores];

	logic [31:0] seen_addr [$];
	logic [31:0] seen_data [$];
	int errors;
	int checks;

	cpu cpu_i (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.data_addr(data_addr),
		.data_read(data_read),
		.data_write(data_write),
		.data_wdata(data_wdata),
		.data_rdata(data_rdata)
	);

	always begin
		#5 clock = ~clock;
	end

	// both memories answer in the same cycle
	always_comb begin
		if (pc < imem_bytes) begin
			instr = imem[pc[7:2]];
		end else begin
			instr = isa_pkg::nop_instr;
		end
	end

	always_comb begin
		if (data_read) begin
			data_rdata = dmem[data_addr[9:2]];
		end else begin
			data_rdata = '0;
		end
	end

	// instruction encoders
	function automatic logic [31:0] rtype(input logic [6:0] funct7, input logic [2:0] funct3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {funct7, rs2, rs1, funct3, rd, isa_pkg::op_rtype};
	endfunction

	function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [31:0] imm);
		return {imm[11:0], rs1, isa_pkg::f3_add_sub, rd, isa_pkg::op_itype};
	endfunction

	function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [31:0] imm);
		return {imm[11:0], rs1, f3_word, rd, isa_pkg::op_load};
	endfunction

	function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [31:0] imm);
		return {imm[11:5], rs2, rs1, f3_word, imm[4:0], isa_pkg::op_store};
	endfunction

	function automatic logic [31:0] beq(input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [31:0] off);
		return {off[12], off[10:5], rs2, rs1, f3_beq, off[4:1], off[11], isa_pkg::op_branch};
	endfunction

	function automatic logic [31:0] jal(input logic [4:0] rd, input logic [31:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, isa_pkg::op_jal};
	endfunction

	`include "test_programs.svh"

	function automatic logic [31:0] expected_data(input int t, input int i);
		logic [31:0] base;
		base = '0;
		if (exp_src[t][i] != no_src) begin
			base = dmem_init[exp_src[t][i] / 4];
		end
		return base + exp_data[t][i];
	endfunction

	task automatic load_memories(input int t);
		int i;
		for (i = 0; i < imem_words; i++) begin
			if (i < prog_len[t]) begin
				imem[i] = prog[t][i];
			end else begin
				imem[i] = isa_pkg::nop_instr;
			end
		end
		for (i = 0; i < dmem_words; i++) begin
			dmem[i] = dmem_init[i];
		end
	endtask

	// reset held for ten cycles while the memories reload
	task automatic apply_reset(input int t);
		int i;
		@(posedge clock);
		reset <= 1'b0;
		for (i = 0; i < reset_cycles; i++) begin
			@(negedge clock);
			if (data_write) begin
				$display("test %s: data_write went high while reset was low", test_name[t]);
				errors++;
			end
			if (data_read) begin
				$display("test %s: data_read went high while reset was low", test_name[t]);
				errors++;
			end
			if (pc != start_pc) begin
				$display("FAILED %s reset pc: expected %h, actual %h",
					test_name[t], start_pc, pc);
				errors++;
			end
		end
		load_memories(t);
		seen_addr.delete();
		seen_data.delete();
		@(posedge clock);
		reset <= 1'b1;
	endtask

	// sampled mid-cycle, the store is written and recorded
	task automatic wait_for_halt(output bit done);
		int cycles;
		done = 1'b0;
		cycles = 0;
		while (!done && cycles < timeout_cycles) begin
			@(negedge clock);
			cycles++;
			if (data_write) begin
				dmem[data_addr[9:2]] = data_wdata;
				seen_addr.push_back(data_addr);
				seen_data.push_back(data_wdata);
				if (data_addr == halt_addr) begin
					done = 1'b1;
				end
			end
		end
	endtask

	task automatic check_stores(input int t);
		int i;
		int n;
		logic [31:0] want;
		if (seen_addr.size() != store_count[t]) begin
			$display("test %s: %0d stores seen where %0d were expected",
				test_name[t], seen_addr.size(), store_count[t]);
			errors++;
		end
		n = (seen_addr.size() < store_count[t]) ? seen_addr.size() : store_count[t];
		for (i = 0; i < n; i++) begin
			want = expected_data(t, i);
			checks += 2;
			if (seen_addr[i] != exp_addr[t][i]) begin
				$display("FAILED %s store %0d address: expected %h, actual %h",
					test_name[t], i, exp_addr[t][i], seen_addr[i]);
				errors++;
			end
			if (seen_data[i] != want) begin
				$display("FAILED %s store %0d data: expected %h, actual %h",
					test_name[t], i, want, seen_data[i]);
				errors++;
			end
		end
	endtask

	initial begin
		int t;
		int i;
		bit done;
		reset = 1'b0;
		errors = 0;
		checks = 0;
		num_tests = 0;
		void'($urandom(82105));
		for (i = 0; i < dmem_words; i++) begin
			dmem_init[i] = $urandom();
		end
		build_table();
		for (t = 0; t < num_tests; t++) begin
			apply_reset(t);
			wait_for_halt(done);
			if (!done) begin
				$display("test %s: no halt store within %0d cycles", test_name[t], timeout_cycles);
				errors++;
			end
			check_stores(t);
		end
		$display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu (
	input logic clock,
	input logic reset,
	output logic [isa_pkg::xlen-1:0] pc,
	input logic [isa_pkg::xlen-1:0] instr,
	output logic [isa_pkg::xlen-1:0] data_addr,
	output logic data_read,
	output logic data_write,
	output logic [isa_pkg::xlen-1:0] data_wdata,
	input logic [isa_pkg::xlen-1:0] data_rdata
);

	pipe_pkg::ifid_t ifid_d;
	pipe_pkg::ifid_t ifid_q;
	pipe_pkg::idex_t idex_d;
	pipe_pkg::idex_t idex_q;
	pipe_pkg::exmem_t exmem_d;
	pipe_pkg::exmem_t exmem_q;
	pipe_pkg::memwb_t memwb_d;
	pipe_pkg::memwb_t memwb_q;

	logic pc_enable;
	logic ifid_enable;
	logic ifid_bubble;
	logic idex_bubble;
	logic redirect;
	logic [isa_pkg::xlen-1:0] next_pc;

	logic [isa_pkg::xlen-1:0] id_instr;
	logic [isa_pkg::xlen-1:0] id_imm;
	logic [isa_pkg::xlen-1:0] rs1_data;
	logic [isa_pkg::xlen-1:0] rs2_data;
	pipe_pkg::alu_op_t id_alu_op;
	logic id_alu_src_imm;
	logic id_mem_read;
	logic id_mem_write;
	logic id_reg_write;
	logic id_is_branch;
	logic id_is_jal;

	pipe_pkg::fwd_sel_t fwd_a;
	pipe_pkg::fwd_sel_t fwd_b;
	logic [isa_pkg::xlen-1:0] ex_rs1_value;
	logic [isa_pkg::xlen-1:0] ex_rs2_value;
	logic [isa_pkg::xlen-1:0] alu_a;
	logic [isa_pkg::xlen-1:0] alu_b;
	logic [isa_pkg::xlen-1:0] alu_result;
	logic alu_equal;

	// operand bypass mux
	function automatic logic [isa_pkg::xlen-1:0] forward(
		input pipe_pkg::fwd_sel_t sel,
		input logic [isa_pkg::xlen-1:0] reg_value,
		input logic [isa_pkg::xlen-1:0] mem_value,
		input logic [isa_pkg::xlen-1:0] wb_value
	);
		case (sel)
			pipe_pkg::from_mem: return mem_value;
			pipe_pkg::from_wb: return wb_value;
			default: return reg_value;
		endcase
	endfunction

	// fetch, target comes from execute
	assign next_pc = redirect ? idex_q.pc + idex_q.imm : pc + isa_pkg::instr_bytes;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= isa_pkg::reset_pc;
		end else if (pc_enable) begin
			pc <= next_pc;
		end
	end

	assign ifid_d.pc = pc;
	assign ifid_d.instr = instr;

	pipe_reg #(.payload_t(pipe_pkg::ifid_t)) ifid_reg (
		.clock(clock),
		.reset(reset),
		.enable(ifid_enable),
		.bubble(ifid_bubble),
		.d(ifid_d),
		.q(ifid_q)
	);

	// decode, an empty ifid slot runs as a nop
	assign id_instr = (ifid_q.instr == '0) ? isa_pkg::nop_instr : ifid_q.instr;

	decoder decoder_inst (
		.instr(id_instr),
		.imm(id_imm),
		.alu_op(id_alu_op),
		.alu_src_imm(id_alu_src_imm),
		.mem_read(id_mem_read),
		.mem_write(id_mem_write),
		.reg_write(id_reg_write),
		.is_branch(id_is_branch),
		.is_jal(id_is_jal)
	);

	reg_file reg_file_inst (
		.clock(clock),
		.reset(reset),
		.read_addr_a(id_instr[19:15]),
		.read_addr_b(id_instr[24:20]),
		.read_data_a(rs1_data),
		.read_data_b(rs2_data),
		.write_addr(memwb_q.rd),
		.write_data(memwb_q.wb_value),
		.write_enable(memwb_q.reg_write)
	);

	always_comb begin
		idex_d.pc = ifid_q.pc;
		idex_d.rs1_data = rs1_data;
		idex_d.rs2_data = rs2_data;
		idex_d.imm = id_imm;
		idex_d.rs1 = id_instr[19:15];
		idex_d.rs2 = id_instr[24:20];
		idex_d.rd = id_instr[11:7];
		idex_d.alu_op = id_alu_op;
		idex_d.alu_src_imm = id_alu_src_imm;
		idex_d.mem_read = id_mem_read;
		idex_d.mem_write = id_mem_write;
		idex_d.reg_write = id_reg_write;
		idex_d.is_branch = id_is_branch;
		idex_d.is_jal = id_is_jal;
		idex_d.valid = (ifid_q.instr != '0);
	end

	hazard_unit hazard_unit_inst (
		.ex_mem_read(idex_q.mem_read),
		.ex_rd(idex_q.rd),
		.id_rs1(idex_d.rs1),
		.id_rs2(idex_d.rs2),
		.ex_rs1(idex_q.rs1),
		.ex_rs2(idex_q.rs2),
		.mem_rd(exmem_q.rd),
		.mem_reg_write(exmem_q.reg_write),
		.wb_rd(memwb_q.rd),
		.wb_reg_write(memwb_q.reg_write),
		.redirect(redirect),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.pc_enable(pc_enable),
		.ifid_enable(ifid_enable),
		.ifid_bubble(ifid_bubble),
		.idex_bubble(idex_bubble)
	);

	pipe_reg #(.payload_t(pipe_pkg::idex_t)) idex_reg (
		.clock(clock),
		.reset(reset),
		.enable(1'b1),
		.bubble(idex_bubble),
		.d(idex_d),
		.q(idex_q)
	);

	// execute
	assign ex_rs1_value = forward(fwd_a, idex_q.rs1_data, exmem_q.alu_result, memwb_q.wb_value);
	assign ex_rs2_value = forward(fwd_b, idex_q.rs2_data, exmem_q.alu_result, memwb_q.wb_value);

	// jal computes its link as pc plus four
	always_comb begin
		if (idex_q.is_jal) begin
			alu_a = idex_q.pc;
			alu_b = isa_pkg::instr_bytes;
		end else begin
			alu_a = ex_rs1_value;
			alu_b = idex_q.alu_src_imm ? idex_q.imm : ex_rs2_value;
		end
	end

	alu alu_inst (
		.op(idex_q.alu_op),
		.a(alu_a),
		.b(alu_b),
		.result(alu_result),
		.equal(alu_equal)
	);

	assign redirect = idex_q.valid && (idex_q.is_jal || (idex_q.is_branch && alu_equal));

	assign exmem_d.alu_result = alu_result;
	assign exmem_d.store_data = ex_rs2_value;
	assign exmem_d.rd = idex_q.rd;
	assign exmem_d.mem_read = idex_q.mem_read;
	assign exmem_d.mem_write = idex_q.mem_write;
	assign exmem_d.reg_write = idex_q.reg_write;

	pipe_reg #(.payload_t(pipe_pkg::exmem_t)) exmem_reg (
		.clock(clock),
		.reset(reset),
		.enable(1'b1),
		.bubble(1'b0),
		.d(exmem_d),
		.q(exmem_q)
	);

	// memory stage drives the data port
	assign data_addr = exmem_q.alu_result;
	assign data_read = exmem_q.mem_read;
	assign data_write = exmem_q.mem_write;
	assign data_wdata = exmem_q.store_data;

	assign memwb_d.wb_value = exmem_q.mem_read ? data_rdata : exmem_q.alu_result;
	assign memwb_d.rd = exmem_q.rd;
	assign memwb_d.reg_write = exmem_q.reg_write;

	pipe_reg #(.payload_t(pipe_pkg::memwb_t)) memwb_reg (
		.clock(clock),
		.reset(reset),
		.enable(1'b1),
		.bubble(1'b0),
		.d(memwb_d),
		.q(memwb_q)
	);

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
	input logic ex_mem_read,
	input logic [isa_pkg::reg_addr_width-1:0] ex_rd,
	input logic [isa_pkg::reg_addr_width-1:0] id_rs1,
	input logic [isa_pkg::reg_addr_width-1:0] id_rs2,
	input logic [isa_pkg::reg_addr_width-1:0] ex_rs1,
	input logic [isa_pkg::reg_addr_width-1:0] ex_rs2,
	input logic [isa_pkg::reg_addr_width-1:0] mem_rd,
	input logic mem_reg_write,
	input logic [isa_pkg::reg_addr_width-1:0] wb_rd,
	input logic wb_reg_write,
	input logic redirect,
	output pipe_pkg::fwd_sel_t fwd_a,
	output pipe_pkg::fwd_sel_t fwd_b,
	output logic pc_enable,
	output logic ifid_enable,
	output logic ifid_bubble,
	output logic idex_bubble
);

	logic load_use;

	// memory stage is younger, so it wins over writeback
	function automatic pipe_pkg::fwd_sel_t select_source(
		input logic [isa_pkg::reg_addr_width-1:0] rs
	);
		if (mem_reg_write && mem_rd != '0 && mem_rd == rs) begin
			return pipe_pkg::from_mem;
		end
		if (wb_reg_write && wb_rd != '0 && wb_rd == rs) begin
			return pipe_pkg::from_wb;
		end
		return pipe_pkg::from_reg;
	endfunction

	always_comb begin
		fwd_a = select_source(ex_rs1);
	end

	always_comb begin
		fwd_b = select_source(ex_rs2);
	end

	// load result is not ready for the next instruction
	assign load_use = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

	// flush beats stall
	assign pc_enable = redirect || !load_use;
	assign ifid_enable = redirect || !load_use;
	assign ifid_bubble = redirect;
	assign idex_bubble = redirect || load_use;

	// a held decode slot is never flushed and leaves a bubble behind it
	always_comb begin
		assert final (pc_enable || (idex_bubble && !ifid_bubble && !ifid_enable));
	end

endmodule

`default_nettype wire

//--- source/decoder.sv
`timescale 1ns/100ps
`default_nettype none

module decoder (
	input logic [isa_pkg::xlen-1:0] instr,
	output logic [isa_pkg::xlen-1:0] imm,
	output pipe_pkg::alu_op_t alu_op,
	output logic alu_src_imm,
	output logic mem_read,
	output logic mem_write,
	output logic reg_write,
	output logic is_branch,
	output logic is_jal
);

	logic [isa_pkg::opcode_width-1:0] opcode;
	logic [isa_pkg::funct3_width-1:0] funct3;
	logic [isa_pkg::funct7_width-1:0] funct7;
	logic [isa_pkg::xlen-1:0] imm_i;
	logic [isa_pkg::xlen-1:0] imm_s;
	logic [isa_pkg::xlen-1:0] imm_b;
	logic [isa_pkg::xlen-1:0] imm_j;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// sign-extended immediates, b and j are halfword offsets
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		// unknown opcodes fall through as a nop
		imm = '0;
		alu_op = pipe_pkg::alu_pass_b;
		alu_src_imm = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		is_branch = 1'b0;
		is_jal = 1'b0;
		case (opcode)
			isa_pkg::op_rtype: begin
				reg_write = 1'b1;
				case (funct3)
					isa_pkg::f3_add_sub: begin
						if (funct7 == isa_pkg::funct7_sub) begin
							alu_op = pipe_pkg::alu_sub;
						end else begin
							alu_op = pipe_pkg::alu_add;
						end
					end
					isa_pkg::f3_slt: alu_op = pipe_pkg::alu_slt;
					isa_pkg::f3_xor: alu_op = pipe_pkg::alu_xor;
					isa_pkg::f3_or: alu_op = pipe_pkg::alu_or;
					isa_pkg::f3_and: alu_op = pipe_pkg::alu_and;
					default: reg_write = 1'b0;
				endcase
			end
			isa_pkg::op_itype: begin
				// addi only
				if (funct3 == isa_pkg::f3_add_sub) begin
					alu_op = pipe_pkg::alu_add;
					alu_src_imm = 1'b1;
					imm = imm_i;
					reg_write = 1'b1;
				end
			end
			isa_pkg::op_load: begin
				alu_op = pipe_pkg::alu_add;
				alu_src_imm = 1'b1;
				imm = imm_i;
				mem_read = 1'b1;
				reg_write = 1'b1;
			end
			isa_pkg::op_store: begin
				alu_op = pipe_pkg::alu_add;
				alu_src_imm = 1'b1;
				imm = imm_s;
				mem_write = 1'b1;
			end
			isa_pkg::op_branch: begin
				alu_op = pipe_pkg::alu_sub;
				imm = imm_b;
				is_branch = 1'b1;
			end
			isa_pkg::op_jal: begin
				// link value is pc plus four out of the alu
				alu_op = pipe_pkg::alu_add;
				imm = imm_j;
				is_jal = 1'b1;
				reg_write = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input pipe_pkg::alu_op_t op,
	input logic [isa_pkg::xlen-1:0] a,
	input logic [isa_pkg::xlen-1:0] b,
	output logic [isa_pkg::xlen-1:0] result,
	output logic equal
);

	logic less;

	// signed compare for slt
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			pipe_pkg::alu_add: begin
				result = a + b;
			end
			pipe_pkg::alu_sub: begin
				result = a - b;
			end
			pipe_pkg::alu_and: begin
				result = a & b;
			end
			pipe_pkg::alu_or: begin
				result = a | b;
			end
			pipe_pkg::alu_xor: begin
				result = a ^ b;
			end
			pipe_pkg::alu_slt: begin
				result = {{(isa_pkg::xlen-1){1'b0}}, less};
			end
			pipe_pkg::alu_pass_b: begin
				result = b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// beq decision
	assign equal = (a == b);

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
	input logic clock,
	input logic reset,
	input logic [4:0] read_addr_a,
	input logic [4:0] read_addr_b,
	output logic [31:0] read_data_a,
	output logic [31:0] read_data_b,
	input logic [4:0] write_addr,
	input logic [31:0] write_data,
	input logic write_enable
);

	logic [31:0] regs [32];

	// x0 is never stored
	always_ff @(posedge clock) begin
		if (write_enable && write_addr != 5'd0) begin
			regs[write_addr] <= write_data;
		end
	end

	// write-through so decode sees the value written back this cycle
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0) begin
			return '0;
		end
		if (write_enable && write_addr == addr) begin
			return write_data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		read_data_a = read_port(read_addr_a);
	end

	always_comb begin
		read_data_b = read_port(read_addr_b);
	end

	assert property (@(posedge clock) disable iff (!reset)
		(read_addr_a != 5'd0 || read_data_a == '0) &&
		(read_addr_b != 5'd0 || read_data_b == '0));

endmodule

`default_nettype wire

//--- source/pipe_reg.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = pipe_pkg::ifid_t
) (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic bubble,
	input payload_t d,
	output payload_t q
);

	// all-zero payload is an invalid slot with every write off
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			q <= '0;
		end else if (bubble) begin
			q <= '0;
		end else if (enable) begin
			q <= d;
		end
	end

	// a held stage keeps its payload into the next cycle
	assert property (@(posedge clock) disable iff (!reset)
		(!enable && !bubble) |=> $stable(q));

endmodule

`default_nettype wire

//--- source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	// operations of the execute stage alu
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_t;

	// source of an execute operand
	typedef enum logic [1:0] {
		from_reg,
		from_mem,
		from_wb
	} fwd_sel_t;

	// fetch to decode
	typedef struct packed {
		logic [isa_pkg::xlen-1:0] pc;
		logic [isa_pkg::xlen-1:0] instr;
	} ifid_t;

	// decode to execute
	typedef struct packed {
		logic [isa_pkg::xlen-1:0] pc;
		logic [isa_pkg::xlen-1:0] rs1_data;
		logic [isa_pkg::xlen-1:0] rs2_data;
		logic [isa_pkg::xlen-1:0] imm;
		logic [isa_pkg::reg_addr_width-1:0] rs1;
		logic [isa_pkg::reg_addr_width-1:0] rs2;
		logic [isa_pkg::reg_addr_width-1:0] rd;
		alu_op_t alu_op;
		logic alu_src_imm;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic is_branch;
		logic is_jal;
		logic valid;
	} idex_t;

	// execute to memory
	typedef struct packed {
		logic [isa_pkg::xlen-1:0] alu_result;
		logic [isa_pkg::xlen-1:0] store_data;
		logic [isa_pkg::reg_addr_width-1:0] rd;
		logic mem_read;
		logic mem_write;
		logic reg_write;
	} exmem_t;

	// memory to writeback
	typedef struct packed {
		logic [isa_pkg::xlen-1:0] wb_value;
		logic [isa_pkg::reg_addr_width-1:0] rd;
		logic reg_write;
	} memwb_t;

endpackage

`default_nettype wire

//--- source/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// data path and register index widths
	localparam int xlen = 32;
	localparam int reg_addr_width = 5;

	// instruction field widths
	localparam int opcode_width = 7;
	localparam int funct3_width = 3;
	localparam int funct7_width = 7;

	// major opcodes of the supported subset
	localparam logic [opcode_width-1:0] op_rtype = 7'b0110011;
	localparam logic [opcode_width-1:0] op_itype = 7'b0010011;
	localparam logic [opcode_width-1:0] op_load = 7'b0000011;
	localparam logic [opcode_width-1:0] op_store = 7'b0100011;
	localparam logic [opcode_width-1:0] op_branch = 7'b1100011;
	localparam logic [opcode_width-1:0] op_jal = 7'b1101111;

	// funct3 selectors for r-type and addi
	localparam logic [funct3_width-1:0] f3_add_sub = 3'b000;
	localparam logic [funct3_width-1:0] f3_slt = 3'b010;
	localparam logic [funct3_width-1:0] f3_xor = 3'b100;
	localparam logic [funct3_width-1:0] f3_or = 3'b110;
	localparam logic [funct3_width-1:0] f3_and = 3'b111;

	// funct7 marks sub against add
	localparam logic [funct7_width-1:0] funct7_sub = 7'b0100000;

	// addi x0, x0, 0
	localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

	// fetch address after reset
	localparam logic [xlen-1:0] reset_pc = '0;

	// size of one instruction word in bytes
	localparam logic [xlen-1:0] instr_bytes = 32'd4;

endpackage

`default_nettype wire
